/* hw/stream_switch_pkg.sv */
/*
 * Shared defaults for the stream switch and the lane index width helper.
 * The lane count is expected to be a power of two so that every dest value names a lane.
 */

package stream_switch_pkg;

    // Width of the data field of each beat
    parameter int data_width_default = 32;

    // Width of the user sideband field
    parameter int user_width_default = 8;

    // Number of lanes, which is also the number of FIFOs
    parameter int lane_count_default = 4;

    // Depth of each lane FIFO in beats, not counting its output register
    parameter int fifo_depth_default = 8;

    // Bits needed to hold a lane index or a dest value
    // A single lane still gets one bit so that no port collapses to zero width
    function automatic int lane_index_width(input int lane_count);
        int width;
        width = $clog2(lane_count);
        if (width < 1) begin
            width = 1;
        end
        return width;
    endfunction

endpackage

/* hw/dest_demux.sv */
/*
 * Zero latency dest decoder feeding the lane FIFOs.
 * A full addressed lane stalls the input even when other lanes have room.
 */

`timescale 1ns/1ps

module dest_demux #(
    parameter int data_width = stream_switch_pkg::data_width_default,
    parameter int user_width = stream_switch_pkg::user_width_default,
    parameter int lane_count = stream_switch_pkg::lane_count_default
) (
    input  logic                                                    in_valid,
    output logic                                                    in_ready,
    input  logic [data_width-1:0]                                   in_data,
    input  logic [user_width-1:0]                                   in_user,
    input  logic                                                    in_last,
    input  logic [stream_switch_pkg::lane_index_width(lane_count)-1:0] in_dest,
    output logic [lane_count-1:0]                                   lane_valid,
    input  logic [lane_count-1:0]                                   lane_ready,
    output logic [data_width-1:0]                                   lane_data,
    output logic [user_width-1:0]                                   lane_user,
    output logic                                                    lane_last
);

    import stream_switch_pkg::*;

    localparam int index_width = lane_index_width(lane_count);

    // The payload goes to every lane, only the valid decides which one takes it
    assign lane_data = in_data;
    assign lane_user = in_user;
    assign lane_last = in_last;

    // One-hot decode of dest, qualified by the input valid
    always_comb begin
        lane_valid = '0;
        for (int lane = 0; lane < lane_count; lane++) begin
            if (in_dest == index_width'(lane)) begin
                lane_valid[lane] = in_valid;
            end
        end
    end

    // The input sees only the ready of the lane it is aiming at
    // Ready does not depend on in_valid, so there is no combinational loop back
    always_comb begin
        in_ready = 1'b0;
        for (int lane = 0; lane < lane_count; lane++) begin
            if (in_dest == index_width'(lane)) begin
                in_ready = lane_ready[lane];
            end
        end
    end

endmodule

/* hw/stream_fifo.sv */
/*
 * Circular buffer stream FIFO with a registered output stage.
 * Holds up to depth beats in memory plus one in the output register.
 * A beat written at one edge reaches out_valid one edge later at the earliest.
 */

`timescale 1ns/1ps

module stream_fifo #(
    parameter int data_width = stream_switch_pkg::data_width_default,
    parameter int user_width = stream_switch_pkg::user_width_default,
    parameter int depth      = stream_switch_pkg::fifo_depth_default
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [data_width-1:0] in_data,
    input  logic [user_width-1:0] in_user,
    input  logic                  in_last,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [data_width-1:0] out_data,
    output logic [user_width-1:0] out_user,
    output logic                  out_last
);

    localparam int ptr_width  = (depth > 1) ? $clog2(depth) : 1;
    localparam int beat_width = data_width + user_width + 1;

    // Beat storage, packed as last, user, data
    logic [beat_width-1:0] memory [depth];

    logic [ptr_width-1:0] write_ptr;
    logic [ptr_width-1:0] read_ptr;

    // Number of beats waiting in memory, the output register is not counted
    logic [ptr_width:0] fill_level;

    logic do_write;
    logic do_read;

    // Step a pointer by one and wrap it at the depth
    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        logic [ptr_width-1:0] result;
        if (ptr == ptr_width'(depth - 1)) begin
            result = '0;
        end else begin
            result = ptr + 1'b1;
        end
        return result;
    endfunction

    // Full means the memory holds depth beats
    assign in_ready = (fill_level != (ptr_width + 1)'(depth));

    assign do_write = in_valid && in_ready;

    // The output register reloads whenever it is empty or its beat is leaving
    // This keeps a steady stream at one beat per cycle
    assign do_read = (fill_level != '0) && (!out_valid || out_ready);

    always_ff @(posedge clock) begin
        if (!reset) begin
            write_ptr  <= '0;
            read_ptr   <= '0;
            fill_level <= '0;
            out_valid  <= 1'b0;
        end else begin
            if (do_write) begin
                write_ptr <= next_ptr(write_ptr);
            end
            if (do_read) begin
                read_ptr  <= next_ptr(read_ptr);
                out_valid <= 1'b1;
            end else if (out_ready) begin
                // The beat left and memory had nothing behind it
                out_valid <= 1'b0;
            end
            // A read and a write in the same cycle leave the level unchanged
            case ({do_write, do_read})
                2'b10:   fill_level <= fill_level + 1'b1;
                2'b01:   fill_level <= fill_level - 1'b1;
                default: fill_level <= fill_level;
            endcase
        end
    end

    // Memory and output payload carry no reset, out_valid qualifies them
    always_ff @(posedge clock) begin
        if (do_write) begin
            memory[write_ptr] <= {in_last, in_user, in_data};
        end
        if (do_read) begin
            {out_last, out_user, out_data} <= memory[read_ptr];
        end
    end

endmodule

/* hw/rr_merger.sv */
/*
 * Packet atomic round robin merger over all lane FIFOs.
 * A grant holds from the first presented beat until a beat with last transfers.
 * The output is combinational from the grant state and the lane inputs.
 */

`timescale 1ns/1ps

module rr_merger #(
    parameter int data_width = stream_switch_pkg::data_width_default,
    parameter int user_width = stream_switch_pkg::user_width_default,
    parameter int lane_count = stream_switch_pkg::lane_count_default
) (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  logic [lane_count-1:0]                                   lane_valid,
    output logic [lane_count-1:0]                                   lane_ready,
    input  logic [lane_count*data_width-1:0]                        lane_data,
    input  logic [lane_count*user_width-1:0]                        lane_user,
    input  logic [lane_count-1:0]                                   lane_last,
    output logic                                                    out_valid,
    input  logic                                                    out_ready,
    output logic [data_width-1:0]                                   out_data,
    output logic [user_width-1:0]                                   out_user,
    output logic                                                    out_last,
    output logic [stream_switch_pkg::lane_index_width(lane_count)-1:0] out_dest
);

    import stream_switch_pkg::*;

    localparam int index_width = lane_index_width(lane_count);

    // Set while a lane owns the output
    logic busy;
    // Lane that owns the output while busy
    logic [index_width-1:0] grant;
    // Lane where the next round robin search starts
    logic [index_width-1:0] pointer;

    logic [index_width-1:0] pick;
    logic [index_width-1:0] active;
    logic                   last_transfer;

    // First requesting lane at or after the pointer
    // Scanning downward lets the lowest offset win; with no request pick stays at the pointer
    always_comb begin
        pick = pointer;
        for (int offset = lane_count - 1; offset >= 0; offset--) begin
            if (lane_valid[(int'(pointer) + offset) % lane_count]) begin
                pick = index_width'((int'(pointer) + offset) % lane_count);
            end
        end
    end

    // An idle merger serves the picked lane in the same cycle
    assign active = busy ? grant : pick;

    assign out_valid = lane_valid[active];
    assign out_data  = lane_data[active*data_width +: data_width];
    assign out_user  = lane_user[active*user_width +: user_width];
    assign out_last  = lane_last[active];
    assign out_dest  = active;

    // Only the lane on the output sees out_ready
    always_comb begin
        lane_ready = '0;
        lane_ready[active] = out_ready;
    end

    assign last_transfer = out_valid && out_ready && out_last;

    always_ff @(posedge clock) begin
        if (!reset) begin
            busy    <= 1'b0;
            grant   <= '0;
            pointer <= '0;
        end else if (last_transfer) begin
            // Packet done, the search restarts just past the lane that was served
            busy <= 1'b0;
            if (active == index_width'(lane_count - 1)) begin
                pointer <= '0;
            end else begin
                pointer <= active + 1'b1;
            end
        end else if (!busy && out_valid) begin
            // A beat is on the output, so the choice is frozen until its packet ends
            // This keeps the output steady under back-pressure
            busy  <= 1'b1;
            grant <= pick;
        end
    end

endmodule

/* hw/stream_switch.sv */
/*
 * Stream packet switch built from a dest demux, one FIFO per lane and a round robin merger.
 * out_dest names the lane a beat came from; a full addressed lane stalls the whole input.
 * The lane count must be a power of two.
 */

`timescale 1ns/1ps

module stream_switch #(
    parameter int data_width = stream_switch_pkg::data_width_default,
    parameter int user_width = stream_switch_pkg::user_width_default,
    parameter int lane_count = stream_switch_pkg::lane_count_default,
    parameter int fifo_depth = stream_switch_pkg::fifo_depth_default
) (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  logic                                                    in_valid,
    output logic                                                    in_ready,
    input  logic [data_width-1:0]                                   in_data,
    input  logic [user_width-1:0]                                   in_user,
    input  logic                                                    in_last,
    input  logic [stream_switch_pkg::lane_index_width(lane_count)-1:0] in_dest,
    output logic                                                    out_valid,
    input  logic                                                    out_ready,
    output logic [data_width-1:0]                                   out_data,
    output logic [user_width-1:0]                                   out_user,
    output logic                                                    out_last,
    output logic [stream_switch_pkg::lane_index_width(lane_count)-1:0] out_dest
);

    // Demux side of each lane, with the payload shared by all FIFOs
    logic [lane_count-1:0] demux_valid;
    logic [lane_count-1:0] demux_ready;
    logic [data_width-1:0] demux_data;
    logic [user_width-1:0] demux_user;
    logic                  demux_last;

    // Merger side of each lane, payload flattened with lane 0 in the low bits
    logic [lane_count-1:0]            fifo_valid;
    logic [lane_count-1:0]            fifo_ready;
    logic [lane_count*data_width-1:0] fifo_data;
    logic [lane_count*user_width-1:0] fifo_user;
    logic [lane_count-1:0]            fifo_last;

    dest_demux #(
        .data_width(data_width),
        .user_width(user_width),
        .lane_count(lane_count)
    ) demux0 (
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .in_user   (in_user),
        .in_last   (in_last),
        .in_dest   (in_dest),
        .lane_valid(demux_valid),
        .lane_ready(demux_ready),
        .lane_data (demux_data),
        .lane_user (demux_user),
        .lane_last (demux_last)
    );

    for (genvar lane = 0; lane < lane_count; lane++) begin : g_lane
        stream_fifo #(
            .data_width(data_width),
            .user_width(user_width),
            .depth     (fifo_depth)
        ) fifo0 (
            .clock    (clock),
            .reset    (reset),
            .in_valid (demux_valid[lane]),
            .in_ready (demux_ready[lane]),
            .in_data  (demux_data),
            .in_user  (demux_user),
            .in_last  (demux_last),
            .out_valid(fifo_valid[lane]),
            .out_ready(fifo_ready[lane]),
            .out_data (fifo_data[lane*data_width +: data_width]),
            .out_user (fifo_user[lane*user_width +: user_width]),
            .out_last (fifo_last[lane])
        );
    end

    rr_merger #(
        .data_width(data_width),
        .user_width(user_width),
        .lane_count(lane_count)
    ) merger0 (
        .clock     (clock),
        .reset     (reset),
        .lane_valid(fifo_valid),
        .lane_ready(fifo_ready),
        .lane_data (fifo_data),
        .lane_user (fifo_user),
        .lane_last (fifo_last),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_user  (out_user),
        .out_last  (out_last),
        .out_dest  (out_dest)
    );

endmodule

/* test/stream_switch_asserts.sv */
/*
 * Output handshake checks, bound to every stream_switch instance.
 * All checks except the reset release check are off while reset is low.
 */

`timescale 1ns/1ps

module stream_switch_asserts #(
    parameter int data_width = stream_switch_pkg::data_width_default,
    parameter int user_width = stream_switch_pkg::user_width_default,
    parameter int lane_count = stream_switch_pkg::lane_count_default
) (
    input logic                                                    clock,
    input logic                                                    reset,
    input logic                                                    in_ready,
    input logic                                                    out_valid,
    input logic                                                    out_ready,
    input logic [data_width-1:0]                                   out_data,
    input logic [user_width-1:0]                                   out_user,
    input logic                                                    out_last,
    input logic [stream_switch_pkg::lane_index_width(lane_count)-1:0] out_dest
);

    // Number of failed checks so far
    int error_count = 0;

    // A stalled beat stays on the output unchanged until it is taken
    property output_held_while_stalled;
        @(posedge clock) disable iff (!reset)
            (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_user)
                && $stable(out_last) && $stable(out_dest));
    endproperty

    // The output valid is always driven to a known level once out of reset
    property output_valid_known;
        @(posedge clock) disable iff (!reset) !$isunknown(out_valid);
    endproperty

    // All FIFOs come out of reset empty, so the input can take a beat at once
    property ready_after_reset;
        @(posedge clock) $rose(reset) |-> in_ready;
    endproperty

    hold_check: assert property (output_held_while_stalled)
        else begin
            error_count++;
            $error("output beat changed while out_ready was low");
        end

    known_check: assert property (output_valid_known)
        else begin
            error_count++;
            $error("out_valid is unknown after reset");
        end

    reset_ready_check: assert property (ready_after_reset)
        else begin
            error_count++;
            $error("in_ready is low in the first cycle after reset");
        end

endmodule

bind stream_switch stream_switch_asserts #(
    .data_width(data_width),
    .user_width(user_width),
    .lane_count(lane_count)
) asserts0 (
    .clock    (clock),
    .reset    (reset),
    .in_ready (in_ready),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_data),
    .out_user (out_user),
    .out_last (out_last),
    .out_dest (out_dest)
);

/* test/stream_switch_tb.sv */
/*
 * Random packet testbench for the stream switch, built on a per-lane queue model.
 * The model tracks the edge each beat was accepted on to know which FIFO heads are visible.
 * Runs with the package defaults for widths, lane count and FIFO depth.
 */

`timescale 1ns/1ps

module stream_switch_tb;

    import stream_switch_pkg::*;

    localparam int data_width     = data_width_default;
    localparam int user_width     = user_width_default;
    localparam int lane_count     = lane_count_default;
    localparam int fifo_depth     = fifo_depth_default;
    localparam int index_width    = lane_index_width(lane_count);
    localparam int clock_period   = 8;
    localparam int reset_cycles   = 10;
    localparam int packet_total   = 400;
    localparam int max_length     = 6;
    localparam int stall_start    = 150;
    localparam int stall_hold     = 64;
    localparam int stall_limit    = 400;
    localparam int idle_checks    = 20;
    localparam int timeout_cycles = packet_total * max_length * 40;

    // One expected beat, with the edge number on which the input took it
    typedef struct packed {
        logic [31:0]           accept;
        logic                  last;
        logic [user_width-1:0] user;
        logic [data_width-1:0] data;
    } beat_t;

    logic                   clock;
    logic                   reset;
    logic                   in_valid;
    logic                   in_ready;
    logic [data_width-1:0]  in_data;
    logic [user_width-1:0]  in_user;
    logic                   in_last;
    logic [index_width-1:0] in_dest;
    logic                   out_valid;
    logic                   out_ready;
    logic [data_width-1:0]  out_data;
    logic [user_width-1:0]  out_user;
    logic                   out_last;
    logic [index_width-1:0] out_dest;

    // Beats accepted but not yet delivered, oldest first, one queue per lane
    beat_t lane_queue [lane_count][$];

    logic [31:0]            rng_state;
    logic [31:0]            edge_count;
    int                     packets_done;
    int                     beat_index;
    int                     packet_length;
    logic [index_width-1:0] packet_dest;
    logic                   in_accepted;
    // Model of the merger grant and its round robin start point
    logic                   locked;
    int                     lock_lane;
    int                     rr_pointer;
    // Sustained output stall used to force back-pressure onto the input
    logic                   stall_active;
    logic                   stall_done;
    logic                   blocked_seen;
    int                     stall_cycles;

    stream_switch #(
        .data_width(data_width),
        .user_width(user_width),
        .lane_count(lane_count),
        .fifo_depth(fifo_depth)
    ) dut0 (
        .clock    (clock),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_data  (in_data),
        .in_user  (in_user),
        .in_last  (in_last),
        .in_dest  (in_dest),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data (out_data),
        .out_user (out_user),
        .out_last (out_last),
        .out_dest (out_dest)
    );

    always #(clock_period / 2) clock = ~clock;

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] draw_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int draw_below(input int bound);
        rng_state = xorshift32(rng_state);
        return int'(rng_state % bound);
    endfunction

    // A FIFO shows its oldest beat one edge after the edge that wrote it
    function automatic logic head_visible(input int lane);
        if (lane_queue[lane].size() == 0) begin
            return 1'b0;
        end
        return lane_queue[lane][0].accept < edge_count;
    endfunction

    // The memory holds every queued beat except a head already in the output register
    function automatic logic lane_has_room(input int lane);
        int in_memory;
        in_memory = lane_queue[lane].size();
        if (head_visible(lane)) begin
            in_memory--;
        end
        return in_memory != fifo_depth;
    endfunction

    // First lane with a visible head, searching from the round robin pointer
    function automatic int next_lane();
        int lane;
        for (int offset = 0; offset < lane_count; offset++) begin
            lane = (rr_pointer + offset) % lane_count;
            if (head_visible(lane)) begin
                return lane;
            end
        end
        return -1;
    endfunction

    function automatic logic queues_empty();
        for (int lane = 0; lane < lane_count; lane++) begin
            if (lane_queue[lane].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Called on the falling edge; a presented beat is held until it was taken
    task automatic drive_inputs();
        if (in_accepted) begin
            in_valid = 1'b0;
            if (in_last) begin
                packets_done++;
                beat_index = 0;
            end else begin
                beat_index++;
            end
        end
        // About one cycle in four leaves a gap on the input
        if (!in_valid && packets_done < packet_total && draw_below(4) != 0) begin
            if (beat_index == 0) begin
                packet_dest   = index_width'(draw_below(lane_count));
                packet_length = 1 + draw_below(max_length);
            end
            in_data  = data_width'(draw_word());
            in_user  = user_width'(draw_word());
            in_last  = (beat_index == packet_length - 1);
            in_dest  = packet_dest;
            in_valid = 1'b1;
        end
        if (!stall_done && !stall_active && packets_done >= stall_start) begin
            stall_active = 1'b1;
            stall_cycles = 0;
        end
        // Outside the stall the sink refuses about a third of the time
        if (stall_active) begin
            out_ready = 1'b0;
        end else begin
            out_ready = (draw_below(3) != 0);
        end
    endtask

    task automatic check_output();
        int    want;
        beat_t head;
        if (!locked) begin
            want = next_lane();
            if (want < 0) begin
                assert (!out_valid)
                    else stop_on_error("out_valid is high although no lane holds a visible beat");
            end else begin
                assert (out_valid)
                    else stop_on_error($sformatf("out_valid is low while lane %0d waits", want));
                assert (int'(out_dest) == want)
                    else stop_on_error($sformatf("MISMATCH out_dest: expected %h, got %h",
                        index_width'(want), out_dest));
            end
        end else begin
            // Mid-packet the granted lane alone owns the output
            assert (int'(out_dest) == lock_lane)
                else stop_on_error($sformatf("MISMATCH out_dest: expected %h, got %h",
                    index_width'(lock_lane), out_dest));
            assert (out_valid == head_visible(lock_lane))
                else stop_on_error($sformatf("MISMATCH out_valid: expected %h, got %h",
                    head_visible(lock_lane), out_valid));
        end
        if (out_valid && out_ready) begin
            head = lane_queue[out_dest][0];
            assert (out_data == head.data)
                else stop_on_error($sformatf("MISMATCH out_data: expected %h, got %h",
                    head.data, out_data));
            assert (out_user == head.user)
                else stop_on_error($sformatf("MISMATCH out_user: expected %h, got %h",
                    head.user, out_user));
            assert (out_last == head.last)
                else stop_on_error($sformatf("MISMATCH out_last: expected %h, got %h",
                    head.last, out_last));
            void'(lane_queue[out_dest].pop_front());
        end
        // The grant ends with a delivered last beat and the search moves past that lane
        if (out_valid && out_ready && out_last) begin
            locked     = 1'b0;
            rr_pointer = (int'(out_dest) + 1) % lane_count;
        end else if (out_valid && !locked) begin
            locked    = 1'b1;
            lock_lane = int'(out_dest);
        end
    endtask

    // Called just before the rising edge, when every input and output has settled
    task automatic sample_cycle();
        beat_t beat;
        assert (dut0.asserts0.error_count == 0)
            else stop_on_error("a bound handshake assertion failed");
        assert (in_ready == lane_has_room(int'(in_dest)))
            else stop_on_error($sformatf("MISMATCH in_ready: expected %h, got %h",
                lane_has_room(int'(in_dest)), in_ready));
        check_output();
        in_accepted = in_valid && in_ready;
        if (in_accepted) begin
            beat.accept = edge_count + 1;
            beat.last   = in_last;
            beat.user   = in_user;
            beat.data   = in_data;
            lane_queue[in_dest].push_back(beat);
        end
        if (stall_active) begin
            stall_cycles++;
            if (in_valid && !in_ready) begin
                blocked_seen = 1'b1;
            end
            assert (blocked_seen || stall_cycles < stall_limit)
                else stop_on_error("in_ready never dropped while the output was stalled");
            if (blocked_seen && stall_cycles >= stall_hold) begin
                stall_active = 1'b0;
                stall_done   = 1'b1;
            end
        end
    endtask

    initial begin
        clock         = 1'b0;
        reset         = 1'b0;
        in_valid      = 1'b0;
        in_data       = '0;
        in_user       = '0;
        in_last       = 1'b0;
        in_dest       = '0;
        out_ready     = 1'b0;
        rng_state     = 32'he6f8;
        edge_count    = '0;
        packets_done  = 0;
        beat_index    = 0;
        packet_length = 1;
        packet_dest   = '0;
        in_accepted   = 1'b0;
        locked        = 1'b0;
        lock_lane     = 0;
        rr_pointer    = 0;
        stall_active  = 1'b0;
        stall_done    = 1'b0;
        blocked_seen  = 1'b0;
        stall_cycles  = 0;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        while (packets_done < packet_total || in_valid || !queues_empty() || locked) begin
            @(negedge clock);
            drive_inputs();
            #(clock_period / 2 - 1);
            sample_cycle();
            @(posedge clock);
            edge_count++;
        end
        // With every beat delivered, nothing more may show up on the output
        repeat (idle_checks) begin
            @(negedge clock);
            out_ready = 1'b1;
            #(clock_period / 2 - 1);
            assert (!out_valid)
                else stop_on_error("out_valid rose after every accepted beat was delivered");
            @(posedge clock);
        end
        @(negedge clock);
        assert (dut0.asserts0.error_count == 0)
            else stop_on_error("a bound handshake assertion failed");
        $display("test passed");
        $finish;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clock);
        stop_on_error($sformatf("Timeout, the run did not finish within %0d cycles",
            timeout_cycles));
    end

endmodule

/* stream_switch.f */
hw/stream_switch_pkg.sv
hw/dest_demux.sv
hw/stream_fifo.sv
hw/rr_merger.sv
hw/stream_switch.sv
test/stream_switch_asserts.sv
test/stream_switch_tb.sv
